/* cpu_pkg.sv */
package cpu_pkg;

    localparam int data_width     = 8;    // Register, ALU and data word width
    localparam int instr_width    = 9;    // Opcode plus operand fields
    localparam int pc_width       = 8;    // Program counter and fetch address
    localparam int imem_depth     = 256;  // Instruction words
    localparam int dmem_depth     = 256;  // Data bytes
    localparam int reg_count      = 4;    // r0 to r3
    localparam int reg_addr_width = 2;    // Register index width

    // All ALU results land in r1
    localparam logic [reg_addr_width-1:0] default_dest = 2'd1;

    // Opcode field in instr[8:6]
    typedef enum logic [2:0] {
        op_add  = 3'd0,  // r1 = ra + rb
        op_sub  = 3'd1,  // r1 = ra - rb
        op_and  = 3'd2,  // r1 = ra & rb
        op_ldi  = 3'd3,  // r1 = sext(imm6)
        op_ld   = 3'd4,  // rb = mem[ra]
        op_st   = 3'd5,  // mem[ra] = rb
        op_bz   = 3'd6,  // Branch relative if r1 == 0
        op_halt = 3'd7   // Stop and raise done
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add    = 2'd0,
        alu_sub    = 2'd1,  // Also used for the branch zero test
        alu_and    = 2'd2,
        alu_pass_b = 2'd3   // Load immediate path
    } alu_op_e;

    typedef enum logic [1:0] {
        st_idle = 2'd0,  // Waiting for first start
        st_run  = 2'd1,  // One instruction per cycle
        st_done = 2'd2   // Halted, done high
    } state_e;

endpackage

/* instruction_memory.sv */
module instruction_memory (
    input  logic                            clk,
    input  logic [cpu_pkg::pc_width-1:0]    pc,         // Fetch address
    input  logic                            busy,       // High while running
    input  logic                            prog_we,    // Load strobe
    input  logic [cpu_pkg::pc_width-1:0]    prog_addr,  // Load address
    input  logic [cpu_pkg::instr_width-1:0] prog_data,  // Load word
    output logic [cpu_pkg::instr_width-1:0] instr       // Fetched instruction
);

    logic [cpu_pkg::instr_width-1:0] mem [cpu_pkg::imem_depth];  // Program store

    logic load_ok;  // Load accepted this cycle

    // The program may only change while the processor is idle or done
    assign load_ok = prog_we && !busy;

    always_ff @(posedge clk) begin
        if (load_ok) begin
            mem[prog_addr] <= prog_data;  // Synchronous load port
        end
    end

    assign instr = mem[pc];  // Asynchronous fetch

endmodule

/* control_decoder.sv */
module control_decoder (
    input  logic [cpu_pkg::instr_width-1:0]    instr,
    output cpu_pkg::alu_op_e                   alu_op,
    output logic [cpu_pkg::reg_addr_width-1:0] ra,
    output logic [cpu_pkg::reg_addr_width-1:0] rb,
    output logic [cpu_pkg::data_width-1:0]     imm,
    output logic                               reg_we,       // Register write request
    output logic                               dest_sel_rb,  // Write rb instead of r1
    output logic                               use_imm,      // ALU takes 0 and imm
    output logic                               mem_read,     // Writeback from memory
    output logic                               mem_write,    // Store request
    output logic                               is_branch,
    output logic                               is_halt
);

    cpu_pkg::opcode_e opcode;  // Decoded opcode field

    assign opcode = cpu_pkg::opcode_e'(instr[8:6]);
    assign ra     = instr[5:4];  // Source A or memory address
    assign rb     = instr[3:2];  // Source B, store data or load target
    assign imm    = {{2{instr[5]}}, instr[5:0]};  // Sign-extend 6 to 8 bits

    always_comb begin
        alu_op      = cpu_pkg::alu_add;  // Defaults are a no-op
        reg_we      = 1'b0;
        dest_sel_rb = 1'b0;
        use_imm     = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        is_branch   = 1'b0;
        is_halt     = 1'b0;
        case (opcode)
            cpu_pkg::op_add: begin
                alu_op = cpu_pkg::alu_add;
                reg_we = 1'b1;
            end
            cpu_pkg::op_sub: begin
                alu_op = cpu_pkg::alu_sub;
                reg_we = 1'b1;
            end
            cpu_pkg::op_and: begin
                alu_op = cpu_pkg::alu_and;
                reg_we = 1'b1;
            end
            cpu_pkg::op_ldi: begin
                alu_op  = cpu_pkg::alu_pass_b;  // 0 and imm, imm passes
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            cpu_pkg::op_ld: begin
                reg_we      = 1'b1;
                dest_sel_rb = 1'b1;  // Load targets rb
                mem_read    = 1'b1;
            end
            cpu_pkg::op_st: begin
                mem_write = 1'b1;
            end
            cpu_pkg::op_bz: begin
                alu_op    = cpu_pkg::alu_sub;  // r1 minus 0 sets zero iff r1 == 0
                is_branch = 1'b1;
            end
            cpu_pkg::op_halt: begin
                is_halt = 1'b1;
            end
            default: begin
                is_halt = 1'b0;  // Unknown fetch does nothing
            end
        endcase
    end

endmodule

/* register_file.sv */
module register_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               busy,    // Gates writes to run state
    input  logic                               we,
    input  logic [cpu_pkg::reg_addr_width-1:0] ra,
    input  logic [cpu_pkg::reg_addr_width-1:0] rb,
    input  logic [cpu_pkg::reg_addr_width-1:0] waddr,
    input  logic [cpu_pkg::data_width-1:0]     wdata,
    output logic [cpu_pkg::data_width-1:0]     data_a,  // Read port A
    output logic [cpu_pkg::data_width-1:0]     data_b,  // Read port B
    output logic [cpu_pkg::data_width-1:0]     data_r1  // Fixed read of r1
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];  // r0 to r3

    logic wr_en;  // Qualified write

    assign wr_en = we && busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;  // Visible from the next cycle
        end
    end

    assign data_a  = regs[ra];
    assign data_b  = regs[rb];
    assign data_r1 = regs[cpu_pkg::default_dest];  // Branch condition source

endmodule

/* alu.sv */
module alu (
    input  logic [cpu_pkg::data_width-1:0] a,
    input  logic [cpu_pkg::data_width-1:0] b,
    input  cpu_pkg::alu_op_e               op,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           zero    // Result is all zeros
);

    always_comb begin
        case (op)
            cpu_pkg::alu_add: begin
                result = a + b;  // Wraps at 8 bits
            end
            cpu_pkg::alu_sub: begin
                result = a - b;  // Wraps at 8 bits
            end
            cpu_pkg::alu_and: begin
                result = a & b;
            end
            cpu_pkg::alu_pass_b: begin
                result = b;  // Immediate load
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);  // Branch test when fed r1 and 0

endmodule

/* data_memory.sv */
module data_memory (
    input  logic                           clk,
    input  logic                           busy,       // Gates stores to run state
    input  logic                           mem_write,  // Store request
    input  logic [cpu_pkg::data_width-1:0] addr,       // Address from ra
    input  logic [cpu_pkg::data_width-1:0] wdata,      // Data from rb
    output logic [cpu_pkg::data_width-1:0] rdata,      // Load data
    input  logic [cpu_pkg::data_width-1:0] dbg_addr,   // Debug read address
    output logic [cpu_pkg::data_width-1:0] dbg_data    // Debug read data
);

    logic [cpu_pkg::data_width-1:0] mem [cpu_pkg::dmem_depth];  // Byte store

    logic wr_en;  // Qualified store

    assign wr_en = mem_write && busy;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wdata;  // Lands at end of the store cycle
        end
    end

    assign rdata    = mem[addr];      // Processor read, asynchronous
    assign dbg_data = mem[dbg_addr];  // Result readout, asynchronous

endmodule

/* sequencer.sv */
module sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,      // One-cycle run request
    input  logic                           is_branch,
    input  logic                           is_halt,
    input  logic                           zero,       // r1 == 0 from the ALU
    input  logic [cpu_pkg::data_width-1:0] imm,        // Signed branch offset
    output logic [cpu_pkg::pc_width-1:0]   pc,
    output logic                           busy,       // High in run only
    output logic                           done        // High in done only
);

    cpu_pkg::state_e state;       // Current state
    cpu_pkg::state_e state_next;

    logic [cpu_pkg::pc_width-1:0] pc_next;
    logic [cpu_pkg::pc_width-1:0] pc_inc;   // Fall-through address
    logic                         taken;    // Branch taken this cycle

    assign pc_inc = pc + 1'b1;
    assign taken  = is_branch && zero;

    always_comb begin
        state_next = state;  // Hold by default
        pc_next    = pc;
        case (state)
            cpu_pkg::st_idle, cpu_pkg::st_done: begin
                if (start) begin
                    state_next = cpu_pkg::st_run;
                    pc_next    = '0;  // Always run from address 0
                end
            end
            cpu_pkg::st_run: begin
                // start has no effect while running
                if (is_halt) begin
                    state_next = cpu_pkg::st_done;  // pc parks on the halt
                end else if (taken) begin
                    pc_next = pc_inc + imm;  // Relative to the next instruction
                end else begin
                    pc_next = pc_inc;
                end
            end
            default: begin
                state_next = cpu_pkg::st_idle;  // Recover from illegal encoding
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::st_idle;
            pc    <= '0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
        end
    end

    assign busy = (state == cpu_pkg::st_run);
    assign done = (state == cpu_pkg::st_done);

endmodule

/* top_level.sv */
module top_level (
    input  logic                            clk,
    input  logic                            rst,        // Synchronous, active high
    input  logic                            start,      // Run request pulse
    output logic                            done,       // Program halted
    input  logic                            prog_we,    // Program load strobe
    input  logic [cpu_pkg::pc_width-1:0]    prog_addr,
    input  logic [cpu_pkg::instr_width-1:0] prog_data,
    input  logic [cpu_pkg::data_width-1:0]  dbg_addr,   // Data memory readout
    output logic [cpu_pkg::data_width-1:0]  dbg_data
);

    logic [cpu_pkg::pc_width-1:0]       pc;
    logic                               busy;
    logic [cpu_pkg::instr_width-1:0]    instr;
    cpu_pkg::alu_op_e                   alu_op;
    logic [cpu_pkg::reg_addr_width-1:0] ra;
    logic [cpu_pkg::reg_addr_width-1:0] rb;
    logic [cpu_pkg::data_width-1:0]     imm;
    logic                               reg_we;
    logic                               dest_sel_rb;
    logic                               use_imm;
    logic                               mem_read;
    logic                               mem_write;
    logic                               is_branch;
    logic                               is_halt;
    logic [cpu_pkg::data_width-1:0]     data_a;
    logic [cpu_pkg::data_width-1:0]     data_b;
    logic [cpu_pkg::data_width-1:0]     data_r1;
    logic [cpu_pkg::data_width-1:0]     alu_a;       // Selected operand A
    logic [cpu_pkg::data_width-1:0]     alu_b;       // Selected operand B
    logic [cpu_pkg::data_width-1:0]     alu_result;
    logic                               zero;
    logic [cpu_pkg::data_width-1:0]     mem_rdata;
    logic [cpu_pkg::reg_addr_width-1:0] waddr;       // Destination register
    logic [cpu_pkg::data_width-1:0]     wdata;       // Writeback value

    // Branch tests r1 against 0, ldi passes imm, else ra and rb
    assign alu_a = is_branch ? data_r1 : (use_imm ? '0 : data_a);
    assign alu_b = is_branch ? '0 : (use_imm ? imm : data_b);
    assign waddr = dest_sel_rb ? rb : cpu_pkg::default_dest;  // Loads write rb
    assign wdata = mem_read ? mem_rdata : alu_result;

    sequencer u_seq (.clk(clk), .rst(rst), .start(start), .is_branch(is_branch),
                     .is_halt(is_halt), .zero(zero), .imm(imm), .pc(pc),
                     .busy(busy), .done(done));

    instruction_memory u_imem (.clk(clk), .pc(pc), .busy(busy), .prog_we(prog_we),
                               .prog_addr(prog_addr), .prog_data(prog_data),
                               .instr(instr));

    control_decoder u_dec (.instr(instr), .alu_op(alu_op), .ra(ra), .rb(rb), .imm(imm),
                           .reg_we(reg_we), .dest_sel_rb(dest_sel_rb), .use_imm(use_imm),
                           .mem_read(mem_read), .mem_write(mem_write),
                           .is_branch(is_branch), .is_halt(is_halt));

    register_file u_rf (.clk(clk), .rst(rst), .busy(busy), .we(reg_we), .ra(ra), .rb(rb),
                        .waddr(waddr), .wdata(wdata), .data_a(data_a), .data_b(data_b),
                        .data_r1(data_r1));

    alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero));

    data_memory u_dmem (.clk(clk), .busy(busy), .mem_write(mem_write), .addr(data_a),
                        .wdata(data_b), .rdata(mem_rdata), .dbg_addr(dbg_addr),
                        .dbg_data(dbg_data));

endmodule

/* cpu_assertions.sv */
module cpu_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         start,
    input logic                         busy,
    input logic                         done,
    input logic [cpu_pkg::pc_width-1:0] pc
);
    timeunit 1ns;
    timeprecision 1ps;

    // Done is only entered straight out of a run
    a_done_after_run: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(busy))
        else $error("done rose without a preceding run cycle");

    // Leaving done needs a start, or a reset
    a_done_falls_on_start: assert property (@(posedge clk) disable iff (rst)
        $fell(done) |-> $past(start || rst))
        else $error("done fell without start");

    a_pc_zero_first_run: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> (pc == '0))  // Every run begins at address 0
        else $error("pc not zero in the first run cycle");

endmodule

bind sequencer cpu_assertions u_seq_assert (.clk(clk), .rst(rst), .start(start),
                                            .busy(busy), .done(done), .pc(pc));

/* tb_top_level.sv */
module tb_top_level;
    timeunit 1ns;
    timeprecision 1ps;

    // Cycle budgets per test, used by the watchdog
    localparam int reset_cycles  = 20;
    localparam int alu_cycles    = 220;
    localparam int load_cycles   = 20;
    localparam int branch_cycles = 170;
    localparam int timing_cycles = 40;
    localparam int lock_cycles   = 170;
    localparam int test_cycles   = reset_cycles + alu_cycles + load_cycles + branch_cycles
                                   + timing_cycles + lock_cycles;

    logic       clk;
    logic       rst;
    logic       start;
    logic       done;
    logic       prog_we;
    logic [7:0] prog_addr;
    logic [8:0] prog_data;
    logic [7:0] dbg_addr;
    logic [7:0] dbg_data;
    logic [8:0] prog [$];  // Program image for the next load
    int         seed_draw;

    top_level u_dut (.clk(clk), .rst(rst), .start(start), .done(done), .prog_we(prog_we),
                     .prog_addr(prog_addr), .prog_data(prog_data), .dbg_addr(dbg_addr),
                     .dbg_data(dbg_data));

    always #10 clk = ~clk;  // 20 ns period

    function automatic logic [8:0] enc_reg(cpu_pkg::opcode_e op, int ra, int rb);
        return {op, ra[1:0], rb[1:0], 2'b00};  // Register form
    endfunction

    function automatic logic [8:0] enc_imm(cpu_pkg::opcode_e op, int imm);
        return {op, imm[5:0]};  // Immediate form, 6-bit two's complement
    endfunction

    function automatic logic [7:0] sign_ext(int v);
        return {{2{v[5]}}, v[5:0]};
    endfunction

    // Reference arithmetic, 8-bit wraparound
    function automatic logic [7:0] alu_model(cpu_pkg::opcode_e op, logic [7:0] x, logic [7:0] y);
        case (op)
            cpu_pkg::op_add: return x + y;
            cpu_pkg::op_sub: return x - y;
            cpu_pkg::op_and: return x & y;
            default:         return 8'h00;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: time %0t: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;  // Drive point after the edge
    endtask

    task automatic check_mem(input string what, input int addr, input logic [7:0] exp);
        logic [7:0] value;
        dbg_addr = addr[7:0];
        #1;  // Combinational readout settles
        value = dbg_data;
        check(what, value, exp);
    endtask

    task automatic load_program;
        for (int i = 0; i < prog.size(); i++) begin
            next_cycle();
            prog_we   = 1'b1;
            prog_addr = i[7:0];
            prog_data = prog[i];
        end
        next_cycle();  // Last word lands on this edge
        prog_we = 1'b0;
    endtask

    // Start pulse, then count edges until done; poke tries loads mid-run
    task automatic run_program(input bit poke, output int cycles);
        next_cycle();
        start = 1'b1;
        next_cycle();
        start  = 1'b0;
        cycles = 1;
        while (!done) begin
            if (poke) begin
                prog_we   = (cycles >= 2 && cycles < 5);  // Busy is high here
                prog_addr = 8'(cycles + 8);               // Inside the loop body
                prog_data = enc_imm(cpu_pkg::op_halt, 0);
            end
            next_cycle();
            cycles++;
        end
        prog_we = 1'b0;
    endtask

    // Countdown of n with iteration count stored at out_addr, 9n+13 instructions
    task automatic build_countdown(input int n, input int out_addr);
        prog.delete();
        prog.push_back(enc_imm(cpu_pkg::op_ldi, 1));
        prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
        prog.push_back(enc_reg(cpu_pkg::op_ld, 0, 2));   // r2 = 1, step and address
        prog.push_back(enc_imm(cpu_pkg::op_ldi, n));
        prog.push_back(enc_reg(cpu_pkg::op_st, 2, 1));   // mem[1] = remaining
        prog.push_back(enc_imm(cpu_pkg::op_ldi, 0));
        prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
        prog.push_back(enc_reg(cpu_pkg::op_ld, 0, 3));   // r3 = count
        prog.push_back(enc_reg(cpu_pkg::op_ld, 2, 1));   // Loop head at 8
        prog.push_back(enc_imm(cpu_pkg::op_bz, 7));      // Exit to 17
        prog.push_back(enc_reg(cpu_pkg::op_sub, 1, 2));
        prog.push_back(enc_reg(cpu_pkg::op_st, 2, 1));
        prog.push_back(enc_reg(cpu_pkg::op_add, 3, 2));
        prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
        prog.push_back(enc_reg(cpu_pkg::op_ld, 0, 3));
        prog.push_back(enc_imm(cpu_pkg::op_ldi, 0));
        prog.push_back(enc_imm(cpu_pkg::op_bz, -9));     // Always taken, back to 8
        prog.push_back(enc_imm(cpu_pkg::op_ldi, out_addr));
        prog.push_back(enc_reg(cpu_pkg::op_st, 1, 3));
        prog.push_back(enc_reg(cpu_pkg::op_halt, 0, 0));
    endtask

    task automatic test_reset;
        check("done after reset", done, 1'b0);
        repeat (5) next_cycle();
        check("done without start", done, 1'b0);
    endtask

    task automatic test_alu;
        cpu_pkg::opcode_e ops [3] = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and};
        int               a;
        int               b;
        int               cycles;
        for (int k = 0; k < 3; k++) begin
            for (int r = 0; r < 3; r++) begin
                a = $urandom % 64;
                b = $urandom % 64;
                prog.delete();
                prog.push_back(enc_imm(cpu_pkg::op_ldi, a));
                prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));   // Move r1 to r2 via mem[0]
                prog.push_back(enc_reg(cpu_pkg::op_ld, 0, 2));
                prog.push_back(enc_imm(cpu_pkg::op_ldi, b));
                prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
                prog.push_back(enc_reg(cpu_pkg::op_ld, 0, 3));
                prog.push_back(enc_reg(ops[k], 2, 3));
                prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
                prog.push_back(enc_reg(cpu_pkg::op_halt, 0, 0));
                load_program();
                run_program(1'b0, cycles);
                check("alu program length", cycles, 10);
                check_mem("alu result", 0, alu_model(ops[k], sign_ext(a), sign_ext(b)));
            end
        end
    endtask

    task automatic test_load;
        int v;
        int cycles;
        v = $urandom % 64;
        prog.delete();
        prog.push_back(enc_imm(cpu_pkg::op_ldi, v));
        prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
        prog.push_back(enc_reg(cpu_pkg::op_ld, 0, 2));  // Load copies into rb
        prog.push_back(enc_imm(cpu_pkg::op_ldi, 20));
        prog.push_back(enc_reg(cpu_pkg::op_st, 1, 2));  // Second address
        prog.push_back(enc_reg(cpu_pkg::op_halt, 0, 0));
        load_program();
        run_program(1'b0, cycles);
        check("load program length", cycles, 7);
        check_mem("stored byte", 0, sign_ext(v));
        check_mem("copied byte", 20, sign_ext(v));
    endtask

    task automatic test_branch;
        int n;
        int cycles;
        n = 1 + $urandom % 12;
        build_countdown(n, 24);
        load_program();
        run_program(1'b0, cycles);
        check("countdown length", cycles, 9 * n + 14);
        check_mem("iteration count", 24, n[7:0]);
        check_mem("remaining count", 1, 8'h00);
        prog.delete();
        prog.push_back(enc_imm(cpu_pkg::op_ldi, 29));
        prog.push_back(enc_imm(cpu_pkg::op_bz, 2));     // r1 nonzero, falls through
        prog.push_back(enc_reg(cpu_pkg::op_st, 0, 1));
        prog.push_back(enc_reg(cpu_pkg::op_halt, 0, 0));
        prog.push_back(enc_reg(cpu_pkg::op_halt, 0, 0));
        load_program();
        run_program(1'b0, cycles);
        check("fall-through length", cycles, 5);
        check_mem("fall-through store", 0, 8'd29);
    endtask

    task automatic test_done_timing;
        int cycles;
        prog.delete();
        for (int i = 1; i <= 5; i++) begin
            prog.push_back(enc_imm(cpu_pkg::op_ldi, i));
        end
        prog.push_back(enc_reg(cpu_pkg::op_halt, 0, 0));  // N = 6
        load_program();
        run_program(1'b0, cycles);
        check("cycles to done", cycles, 7);
        repeat (3) next_cycle();
        check("done held", done, 1'b1);
        run_program(1'b0, cycles);                        // Restart from done
        check("cycles to done on rerun", cycles, 7);
    endtask

    task automatic test_load_lock;
        int cycles;
        build_countdown(6, 28);
        load_program();
        run_program(1'b1, cycles);                        // Writes halt into the loop
        check("locked run length", cycles, 68);
        check_mem("locked run count", 28, 8'd6);
        run_program(1'b0, cycles);
        check("rerun length", cycles, 68);
        check_mem("rerun count", 28, 8'd6);
    endtask

    initial begin
        seed_draw = $urandom(32'h005e2958);
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset();
        test_alu();
        test_load();
        test_branch();
        test_done_timing();
        test_load_lock();
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(2 * test_cycles * 20);  // Twice the summed budgets, in ns
        $display("watchdog: the run timed out before all tests finished");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

/* list.f */
cpu_pkg.sv
instruction_memory.sv
control_decoder.sv
register_file.sv
alu.sv
data_memory.sv
sequencer.sv
top_level.sv
cpu_assertions.sv
tb_top_level.sv

/* Bender.yml */
package:
  name: cpu8

sources:
  - cpu_pkg.sv
  - instruction_memory.sv
  - control_decoder.sv
  - register_file.sv
  - alu.sv
  - data_memory.sv
  - sequencer.sv
  - top_level.sv
  - target: test
    files:
      - cpu_assertions.sv
      - tb_top_level.sv
